//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_replica_move -o sim_replica_move
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/sim_replica_move 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- source/move_judge.sv
module move_judge #(
    parameter int REPLICA_NUM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 thr_load,
    input  tsp_pkg::replica_id_t thr_replica,
    input  tsp_pkg::rand_word_t  thr_metro,
    input  tsp_pkg::rand_word_t  thr_exch,
    input  logic                 ready,
    input  tsp_pkg::replica_id_t replica,
    input  move_pkg::opt_kind_t  kind,
    input  tsp_pkg::city_idx_t   move_k,
    input  tsp_pkg::city_idx_t   move_l,
    input  tsp_pkg::rand_word_t  r_metro,
    input  tsp_pkg::rand_word_t  r_exch,
    output logic                 move_valid,
    output tsp_pkg::replica_id_t move_replica,
    output move_pkg::opt_kind_t  move_kind,
    output tsp_pkg::city_idx_t   out_k,
    output tsp_pkg::city_idx_t   out_l,
    output logic                 metro_accept,
    output logic                 exch_accept,
    output logic                 record_done
);
    import tsp_pkg::*;

    localparam int REP_W = $clog2(REPLICA_NUM);

    rand_word_t thr_metro_tab [REPLICA_NUM];
    rand_word_t thr_exch_tab  [REPLICA_NUM];
    logic       ready_q;
    logic       capture;

    assign capture     = ready && !ready_q; // Generator just finished
    assign record_done = move_valid;

    // Zero thresholds reject everything
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REPLICA_NUM; i++) begin
                thr_metro_tab[i] <= '0;
                thr_exch_tab[i]  <= '0;
            end
        end else if (thr_load) begin
            thr_metro_tab[thr_replica[REP_W-1:0]] <= thr_metro;
            thr_exch_tab[thr_replica[REP_W-1:0]]  <= thr_exch;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q    <= 1'b0;
            move_valid <= 1'b0;
        end else begin
            ready_q    <= ready;
            move_valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            move_replica <= replica;
            move_kind    <= kind;
            out_k        <= move_k;
            out_l        <= move_l;
            metro_accept <= (r_metro < thr_metro_tab[replica[REP_W-1:0]]);
            exch_accept  <= (r_exch < thr_exch_tab[replica[REP_W-1:0]]);
        end
    end

    // Loads are held off by busy upstream
    a_no_thr_race: assert property (@(posedge clk) disable iff (reset)
        !(thr_load && capture && thr_replica == replica));

endmodule

//--- source/move_pkg.sv
package move_pkg;

    ////////////////////
    // Move kinds
    ////////////////////

    // NONE is never sent to the generator
    typedef enum logic [1:0] {
        NONE = 2'b00,
        OR1  = 2'b01, // or-opt
        TWO  = 2'b10  // 2-opt
    } opt_kind_t;

    ////////////////////
    // Generator phases
    ////////////////////

    // One draw per cycle in each phase
    typedef enum logic [1:0] {
        S_K     = 2'b00,
        S_L     = 2'b01,
        S_METRO = 2'b10,
        S_EXCH  = 2'b11
    } gen_state_t;

endpackage

//--- source/opt_move_gen.sv
module opt_move_gen #(
    parameter int CITY_NUM    = 20,
    parameter int REPLICA_NUM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  tsp_pkg::replica_id_t replica,
    input  move_pkg::opt_kind_t  kind,
    input  logic                 init,
    input  tsp_pkg::replica_id_t init_replica,
    input  tsp_pkg::seed_t       init_seed,
    output tsp_pkg::city_idx_t   move_k,
    output tsp_pkg::city_idx_t   move_l,
    output tsp_pkg::rand_word_t  r_metro,
    output tsp_pkg::rand_word_t  r_exch,
    output logic                 ready
);
    import tsp_pkg::*;
    import move_pkg::*;

    localparam int REP_W = $clog2(REPLICA_NUM);

    localparam rand_word_t MASK_TWO = rand_word_t'((64'd1 << $clog2(CITY_NUM)) - 64'd1);
    localparam rand_word_t MASK_OR1 = rand_word_t'((64'd1 << $clog2(CITY_NUM - 1)) - 64'd1);
    localparam rand_word_t TOP_TWO  = rand_word_t'(CITY_NUM);
    localparam rand_word_t TOP_OR1  = rand_word_t'(CITY_NUM - 1);

    seed_t       seed_mem [REPLICA_NUM];
    seed_t       x0;
    seed_t       x1;
    seed_t       x2;
    seed_t       x3;
    rand_word_t  draw_mask;
    rand_word_t  draw;
    city_idx_t   draw_idx;
    replica_id_t cur_replica;
    opt_kind_t   cur_kind;
    gen_state_t  state;
    logic        sampling;
    logic        step;
    logic        is_two;
    logic        k_ok;
    logic        l_ok;
    logic        pair_ok;

    ////////////////////
    // Draw datapath
    ////////////////////

    always_comb begin
        is_two = (cur_kind == TWO);
        step   = sampling && !run;

        x0 = seed_mem[cur_replica[REP_W-1:0]];
        x1 = x0 ^ (x0 << 13);
        x2 = x1 ^ (x1 >> 7);
        x3 = x2 ^ (x2 << 17);

        // Acceptance words are taken whole
        if (state == S_METRO || state == S_EXCH) begin
            draw_mask = '1;
        end else if (is_two) begin
            draw_mask = MASK_TWO;
        end else begin
            draw_mask = MASK_OR1;
        end
        draw     = x3[31:0] & draw_mask;
        draw_idx = city_idx_t'(draw);

        k_ok = (draw >= 32'd1) && (draw <= (is_two ? TOP_TWO : TOP_OR1));
        l_ok = is_two ? ((draw >= 32'd1) && (draw <= TOP_TWO)) : (draw <= TOP_OR1);

        // Degenerate pairs send us back to K
        pair_ok = (draw_idx != move_k);
        if (!is_two && (draw_idx + 8'd1 == move_k)) begin
            pair_ok = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (init) begin
            seed_mem[init_replica[REP_W-1:0]] <= init_seed;
        end else if (step) begin
            seed_mem[cur_replica[REP_W-1:0]] <= x3; // Advance this replica only
        end
    end

    ////////////////////
    // Phase control
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sampling <= 1'b0;
            ready    <= 1'b0;
            state    <= S_K;
        end else if (run) begin
            sampling <= 1'b1;
            ready    <= 1'b0;
            state    <= S_K;
        end else if (sampling) begin
            case (state)
                S_K: begin
                    if (k_ok) begin
                        state <= S_L;
                    end
                end
                S_L: begin
                    if (l_ok) begin
                        state <= pair_ok ? S_METRO : S_K;
                    end
                end
                S_METRO: state <= S_EXCH;
                S_EXCH: begin
                    state    <= S_K;
                    sampling <= 1'b0;
                    ready    <= 1'b1;
                end
                default: state <= S_K;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            cur_replica <= replica;
            cur_kind    <= kind;
        end else if (sampling) begin
            case (state)
                S_K: begin
                    if (k_ok) begin
                        move_k <= draw_idx;
                    end
                end
                S_L: begin
                    if (l_ok && pair_ok) begin
                        // 2-opt keeps K below L
                        if (is_two && (draw_idx < move_k)) begin
                            move_k <= draw_idx;
                            move_l <= move_k;
                        end else begin
                            move_l <= draw_idx;
                        end
                    end
                end
                S_METRO: r_metro <= draw;
                S_EXCH:  r_exch  <= draw;
                default: ;
            endcase
        end
    end

    a_pair_in_range: assert property (@(posedge clk) disable iff (reset)
        $rose(ready) |-> (is_two
            ? (move_k != 8'd0 && move_k < move_l && move_l <= city_idx_t'(CITY_NUM))
            : (move_k != 8'd0 && move_k < city_idx_t'(CITY_NUM)
               && move_l < city_idx_t'(CITY_NUM)
               && move_l != move_k && move_l + 8'd1 != move_k)));

endmodule

//--- source/replica_move_top.sv
module replica_move_top #(
    parameter int CITY_NUM    = 20,
    parameter int REPLICA_NUM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sweep_start,
    input  move_pkg::opt_kind_t  sweep_kind,
    input  logic                 seed_load,
    input  tsp_pkg::replica_id_t seed_replica,
    input  tsp_pkg::seed_t       seed_value,
    input  logic                 thr_load,
    input  tsp_pkg::replica_id_t thr_replica,
    input  tsp_pkg::rand_word_t  thr_metro,
    input  tsp_pkg::rand_word_t  thr_exch,
    output logic                 move_valid,
    output tsp_pkg::replica_id_t move_replica,
    output move_pkg::opt_kind_t  move_kind,
    output tsp_pkg::city_idx_t   move_k,
    output tsp_pkg::city_idx_t   move_l,
    output logic                 metro_accept,
    output logic                 exch_accept,
    output logic                 busy,
    output logic                 sweep_done
);
    import tsp_pkg::*;
    import move_pkg::*;

    logic        run;
    replica_id_t replica;
    opt_kind_t   kind;
    logic        init;
    seed_t       init_seed;
    replica_id_t init_replica;
    city_idx_t   gen_k;
    city_idx_t   gen_l;
    rand_word_t  r_metro;
    rand_word_t  r_exch;
    logic        ready;
    logic        record_done;
    logic        thr_load_idle;

    assign thr_load_idle = thr_load && !busy; // Tables frozen during a sweep

    sweep_decode #(
        .REPLICA_NUM (REPLICA_NUM)
    ) u_sweep_decode (
        .clk          (clk),
        .reset        (reset),
        .sweep_start  (sweep_start),
        .sweep_kind   (sweep_kind),
        .seed_load    (seed_load),
        .seed_replica (seed_replica),
        .seed_value   (seed_value),
        .record_done  (record_done),
        .run          (run),
        .replica      (replica),
        .kind         (kind),
        .init         (init),
        .init_seed    (init_seed),
        .init_replica (init_replica),
        .busy         (busy),
        .sweep_done   (sweep_done)
    );

    opt_move_gen #(
        .CITY_NUM    (CITY_NUM),
        .REPLICA_NUM (REPLICA_NUM)
    ) u_opt_move_gen (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .replica      (replica),
        .kind         (kind),
        .init         (init),
        .init_replica (init_replica),
        .init_seed    (init_seed),
        .move_k       (gen_k),
        .move_l       (gen_l),
        .r_metro      (r_metro),
        .r_exch       (r_exch),
        .ready        (ready)
    );

    move_judge #(
        .REPLICA_NUM (REPLICA_NUM)
    ) u_move_judge (
        .clk          (clk),
        .reset        (reset),
        .thr_load     (thr_load_idle),
        .thr_replica  (thr_replica),
        .thr_metro    (thr_metro),
        .thr_exch     (thr_exch),
        .ready        (ready),
        .replica      (replica),
        .kind         (kind),
        .move_k       (gen_k),
        .move_l       (gen_l),
        .r_metro      (r_metro),
        .r_exch       (r_exch),
        .move_valid   (move_valid),
        .move_replica (move_replica),
        .move_kind    (move_kind),
        .out_k        (move_k),
        .out_l        (move_l),
        .metro_accept (metro_accept),
        .exch_accept  (exch_accept),
        .record_done  (record_done)
    );

endmodule

//--- source/sweep_decode.sv
module sweep_decode #(
    parameter int REPLICA_NUM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sweep_start,
    input  move_pkg::opt_kind_t  sweep_kind,
    input  logic                 seed_load,
    input  tsp_pkg::replica_id_t seed_replica,
    input  tsp_pkg::seed_t       seed_value,
    input  logic                 record_done,
    output logic                 run,
    output tsp_pkg::replica_id_t replica,
    output move_pkg::opt_kind_t  kind,
    output logic                 init,
    output tsp_pkg::seed_t       init_seed,
    output tsp_pkg::replica_id_t init_replica,
    output logic                 busy,
    output logic                 sweep_done
);
    import tsp_pkg::*;
    import move_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } dec_state_t;

    localparam replica_id_t LAST = replica_id_t'(REPLICA_NUM - 1);

    dec_state_t state;
    logic       start_ok;

    assign start_ok = sweep_start && (sweep_kind != NONE) && (state == IDLE);
    assign run      = (state == ISSUE); // One cycle per replica
    assign busy     = (state != IDLE);

    // Seed loads pass through only between sweeps
    assign init         = seed_load && (state == IDLE);
    assign init_seed    = seed_value;
    assign init_replica = seed_replica;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            replica    <= '0;
            kind       <= NONE;
            sweep_done <= 1'b0;
        end else begin
            sweep_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        state   <= ISSUE;
                        replica <= '0;
                        kind    <= sweep_kind;
                    end
                end
                ISSUE: state <= WAIT;
                WAIT: begin
                    if (record_done) begin
                        if (replica == LAST) begin
                            state      <= IDLE;
                            sweep_done <= 1'b1; // Falls with busy
                        end else begin
                            state   <= ISSUE;
                            replica <= replica + replica_id_t'(1);
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Shared sampling datapath, one replica in flight
    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        record_done |-> (state == WAIT));

endmodule

//--- source/tsp_pkg.sv
package tsp_pkg;

    ////////////////////
    // Problem size
    ////////////////////

    // Tour position, must hold CITY_NUM
    typedef logic [7:0] city_idx_t;

    // Replica number, must hold REPLICA_NUM-1
    typedef logic [2:0] replica_id_t;

    ////////////////////
    // Random numbers
    ////////////////////

    typedef logic [63:0] seed_t;      // Xorshift state
    typedef logic [31:0] rand_word_t; // Low half of the state

endpackage

//--- tb.f
source/tsp_pkg.sv
source/move_pkg.sv
source/sweep_decode.sv
source/opt_move_gen.sv
source/move_judge.sv
source/replica_move_top.sv
test/tb_replica_move.sv

//--- test/tb_replica_move.sv
module tb_replica_move;
    import tsp_pkg::*;
    import move_pkg::*;

    localparam int CITY_NUM       = 20;
    localparam int REPLICA_NUM    = 4;
    localparam int NUM_SWEEPS     = 5;
    localparam int TIMEOUT_CYCLES = NUM_SWEEPS * REPLICA_NUM * 200;

    logic        clk;
    logic        reset;
    logic        sweep_start;
    opt_kind_t   sweep_kind;
    logic        seed_load;
    replica_id_t seed_replica;
    seed_t       seed_value;
    logic        thr_load;
    replica_id_t thr_replica;
    rand_word_t  thr_metro;
    rand_word_t  thr_exch;
    logic        move_valid;
    replica_id_t move_replica;
    opt_kind_t   move_kind;
    city_idx_t   move_k;
    city_idx_t   move_l;
    logic        metro_accept;
    logic        exch_accept;
    logic        busy;
    logic        sweep_done;

    seed_t       seed_model [REPLICA_NUM];      // Reference xorshift state
    rand_word_t  thr_metro_model [REPLICA_NUM];
    rand_word_t  thr_exch_model [REPLICA_NUM];
    logic [15:0] lfsr_state;

    replica_move_top #(
        .CITY_NUM    (CITY_NUM),
        .REPLICA_NUM (REPLICA_NUM)
    ) u_replica_move_top (
        .clk          (clk),
        .reset        (reset),
        .sweep_start  (sweep_start),
        .sweep_kind   (sweep_kind),
        .seed_load    (seed_load),
        .seed_replica (seed_replica),
        .seed_value   (seed_value),
        .thr_load     (thr_load),
        .thr_replica  (thr_replica),
        .thr_metro    (thr_metro),
        .thr_exch     (thr_exch),
        .move_valid   (move_valid),
        .move_replica (move_replica),
        .move_kind    (move_kind),
        .move_k       (move_k),
        .move_l       (move_l),
        .metro_accept (metro_accept),
        .exch_accept  (exch_accept),
        .busy         (busy),
        .sweep_done   (sweep_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Models
    ////////////////////

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [63:0] lfsr_take(input int nbits);
        logic [63:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits = {bits[62:0], fb};
        end
        return bits;
    endfunction

    function automatic seed_t xorshift(input seed_t x);
        seed_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        return y ^ (y << 17);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("Error at %0t: %s", $time, what);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Rejection sampling of K and L, then the two acceptance words
    task automatic predict_move(input int r, input opt_kind_t kd, output city_idx_t k,
                                output city_idx_t l, output rand_word_t rm,
                                output rand_word_t re);
        int    phase;
        int    top;
        int    v;
        int    mask;
        int    tries;
        seed_t s;
        phase = 0;
        tries = 0;
        k     = '0;
        l     = '0;
        rm    = '0;
        re    = '0;
        top   = (kd == TWO) ? CITY_NUM : CITY_NUM - 1;
        mask  = (kd == TWO) ? (1 << $clog2(CITY_NUM)) - 1 : (1 << $clog2(CITY_NUM - 1)) - 1;
        while (phase < 4 && tries < 100000) begin
            s = xorshift(seed_model[r]);
            seed_model[r] = s;
            v = int'(s[31:0]) & mask;
            tries++;
            case (phase)
                0: begin
                    if (v >= 1 && v <= top) begin
                        k     = city_idx_t'(v);
                        phase = 1;
                    end
                end
                1: begin
                    if ((v >= 1 || kd == OR1) && v <= top) begin
                        if (v == int'(k) || (kd == OR1 && v + 1 == int'(k))) begin
                            phase = 0; // Degenerate, new K
                        end else if (kd == TWO && v < int'(k)) begin
                            l     = k;
                            k     = city_idx_t'(v);
                            phase = 2;
                        end else begin
                            l     = city_idx_t'(v);
                            phase = 2;
                        end
                    end
                end
                2: begin
                    rm    = s[31:0];
                    phase = 3;
                end
                default: begin
                    re    = s[31:0];
                    phase = 4;
                end
            endcase
        end
        check_true("reference model found no legal move", phase == 4);
    endtask

    ////////////////////
    // Host actions
    ////////////////////

    task automatic load_seed(input int r, input seed_t s);
        @(posedge clk);
        seed_load    <= 1'b1;
        seed_replica <= replica_id_t'(r);
        seed_value   <= s;
        @(posedge clk);
        seed_load    <= 1'b0;
        seed_model[r] = s;
    endtask

    task automatic load_thresholds(input int r, input rand_word_t m, input rand_word_t e);
        @(posedge clk);
        thr_load    <= 1'b1;
        thr_replica <= replica_id_t'(r);
        thr_metro   <= m;
        thr_exch    <= e;
        @(posedge clk);
        thr_load    <= 1'b0;
        thr_metro_model[r] = m;
        thr_exch_model[r]  = e;
    endtask

    task automatic wait_record();
        do begin
            @(negedge clk);
        end while (move_valid !== 1'b1);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic check_none_start();
        @(negedge clk);
        check_value("busy", 64'(busy), 64'd0);
        check_value("move_valid", 64'(move_valid), 64'd0);
        check_value("sweep_done", 64'(sweep_done), 64'd0);
        @(posedge clk);
        sweep_start <= 1'b1;
        sweep_kind  <= NONE;
        @(posedge clk);
        sweep_start <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_value("busy", 64'(busy), 64'd0);
            check_value("move_valid", 64'(move_valid), 64'd0);
        end
    endtask

    // With poke set, a second start is raised while the sweep runs
    task automatic run_sweep(input opt_kind_t kd, input logic poke);
        city_idx_t  exp_k;
        city_idx_t  exp_l;
        rand_word_t exp_rm;
        rand_word_t exp_re;
        @(posedge clk);
        sweep_start <= 1'b1;
        sweep_kind  <= kd;
        @(posedge clk);
        sweep_start <= poke;
        @(negedge clk);
        check_value("busy", 64'(busy), 64'd1);
        @(posedge clk);
        sweep_start <= 1'b0;
        for (int r = 0; r < REPLICA_NUM; r++) begin
            predict_move(r, kd, exp_k, exp_l, exp_rm, exp_re);
            wait_record();
            check_value("move_replica", 64'(move_replica), 64'(r));
            check_value("move_kind", 64'(move_kind), 64'(kd));
            check_value("move_k", 64'(move_k), 64'(exp_k));
            check_value("move_l", 64'(move_l), 64'(exp_l));
            check_value("metro_accept", 64'(metro_accept), 64'(exp_rm < thr_metro_model[r]));
            check_value("exch_accept", 64'(exch_accept), 64'(exp_re < thr_exch_model[r]));
            if (kd == TWO) begin
                check_true("2-opt pair out of order or out of range",
                    int'(move_k) >= 1 && int'(move_k) < int'(move_l)
                    && int'(move_l) <= CITY_NUM);
            end else begin
                check_true("or-opt pair out of range or degenerate",
                    int'(move_k) >= 1 && int'(move_k) <= CITY_NUM - 1
                    && int'(move_l) <= CITY_NUM - 1 && move_l != move_k
                    && int'(move_l) + 1 != int'(move_k));
            end
            @(negedge clk);
            check_value("move_valid", 64'(move_valid), 64'd0);
            check_value("sweep_done", 64'(sweep_done), 64'(r == REPLICA_NUM - 1));
            check_value("busy", 64'(busy), 64'(r != REPLICA_NUM - 1));
        end
        if (poke) begin
            repeat (4) begin
                @(negedge clk);
                check_value("busy", 64'(busy), 64'd0);
                check_value("move_valid", 64'(move_valid), 64'd0);
            end
        end
    endtask

    initial begin
        seed_t saved_seed;
        reset        = 1'b1;
        sweep_start  = 1'b0;
        sweep_kind   = NONE;
        seed_load    = 1'b0;
        seed_replica = '0;
        seed_value   = '0;
        thr_load     = 1'b0;
        thr_replica  = '0;
        thr_metro    = '0;
        thr_exch     = '0;
        lfsr_state   = 16'd45;
        for (int r = 0; r < REPLICA_NUM; r++) begin
            seed_model[r]      = '0;
            thr_metro_model[r] = '0; // Matches the reset tables
            thr_exch_model[r]  = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        check_none_start();
        for (int r = 0; r < REPLICA_NUM; r++) begin
            load_seed(r, lfsr_take(64) | 64'd1); // Zero state would never move
        end
        saved_seed = seed_model[2];
        run_sweep(TWO, 1'b0);
        for (int r = 0; r < REPLICA_NUM; r++) begin
            load_thresholds(r, rand_word_t'(lfsr_take(32)), rand_word_t'(lfsr_take(32)));
        end
        run_sweep(OR1, 1'b0);
        run_sweep(TWO, 1'b1);
        run_sweep(OR1, 1'b0);
        load_seed(2, saved_seed); // Replica 2 starts its stream over
        run_sweep(TWO, 1'b1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
